// ==== Bender.yml ====
package:
  name: fft_stage

sources:
  - include_dirs:
      - include
    files:
      - logic/fft_pkg.sv
      - logic/csr_pkg.sv
      - logic/frame_pairer.sv
      - logic/butterfly_stage.sv
      - logic/fft_csr.sv
      - logic/fft_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/fft_props.sv
      - test/tb_fft_top.sv

// ==== compile.f ====
+incdir+include
logic/fft_pkg.sv
logic/csr_pkg.sv
logic/frame_pairer.sv
logic/butterfly_stage.sv
logic/fft_csr.sv
logic/fft_top.sv
test/fft_props.sv
test/tb_fft_top.sv

// ==== include/fft_settings.svh ====
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// Datapath geometry and timing.
`define FFT_LANES   16
`define FFT_TW_FRAC 8
`define FFT_SR_HOLD 9

// Register offsets in bytes.
`define FFT_ADDR_CTRL  8'h00
`define FFT_ADDR_COUNT 8'h04
`define FFT_ADDR_ID    8'h08

`define FFT_ID_VALUE 32'hFF72_0001

`endif

// ==== logic/butterfly_stage.sv ====
`default_nettype none
`include "fft_settings.svh"

module butterfly_stage (
    input  logic               clk,
    input  logic               rstn,
    input  logic               pair_valid,
    input  fft_pkg::pair_t     pair,
    input  csr_pkg::ctrl_t     ctrl,
    output logic               out_valid,
    output fft_pkg::bfly_out_t out_data,
    output logic               sr_valid
);

    typedef struct packed {
        fft_pkg::sum_t re;
        fft_pkg::sum_t im;
    } cplx_sum_t;

    typedef struct packed {
        fft_pkg::twiddle_t re;
        fft_pkg::twiddle_t im;
    } cplx_tw_t;

    localparam int HOLD_W = $clog2(`FFT_SR_HOLD + 1);

    cplx_sum_t [`FFT_LANES-1:0] sum_q;
    cplx_sum_t [`FFT_LANES-1:0] dif_q;
    logic                       s1_valid;
    logic [3:0]                 blk_cnt;
    logic [HOLD_W-1:0]          hold_cnt;
    cplx_tw_t                   tw_add;
    cplx_tw_t                   tw_dif;
    fft_pkg::bfly_out_t         rot;

    // Full complex product, then a floor shift back to the sample scale.
    function automatic fft_pkg::cplx_out_t rotate(cplx_sum_t x, cplx_tw_t w);
        logic signed [21:0] pr;
        logic signed [21:0] pi;
        fft_pkg::cplx_out_t y;
        pr = x.re * w.re - x.im * w.im;
        pi = x.re * w.im + x.im * w.re;
        pr = pr >>> `FFT_TW_FRAC;
        pi = pi >>> `FFT_TW_FRAC;
        y.re = pr[12:0];
        y.im = pi[12:0];
        return y;
    endfunction

    // Entries 0 and 2 are unity on both branches.
    always_comb begin
        tw_add = '{re: 10'sd256, im: 10'sd0};
        tw_dif = '{re: 10'sd256, im: 10'sd0};
        if (!ctrl.bypass) begin
            case (blk_cnt[3:2])
                2'd1: tw_dif = '{re: 10'sd0, im: -10'sd256};   // -j
                2'd3: begin
                    tw_add = '{re: 10'sd181, im: -10'sd181};
                    tw_dif = '{re: -10'sd181, im: -10'sd181};
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < `FFT_LANES; i++) begin
            rot.add[i]  = rotate(sum_q[i], tw_add);
            rot.diff[i] = rotate(dif_q[i], tw_dif);
        end
    end

    always_ff @(posedge clk) begin
        if (pair_valid) begin
            for (int i = 0; i < `FFT_LANES; i++) begin
                sum_q[i].re <= pair.a[i].re + pair.b[i].re;
                sum_q[i].im <= pair.a[i].im + pair.b[i].im;
                dif_q[i].re <= pair.a[i].re - pair.b[i].re;
                dif_q[i].im <= pair.a[i].im - pair.b[i].im;
            end
        end
        if (s1_valid) begin
            out_data <= rot;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
            blk_cnt   <= '0;
        end else begin
            s1_valid  <= pair_valid;
            out_valid <= s1_valid;
            if (ctrl.clear) begin
                blk_cnt <= '0;
            end else if (s1_valid) begin
                blk_cnt <= blk_cnt + 4'd1;   // Advances once per rotated block.
            end
        end
    end

    // The strobe stretches past the last block for the next stage.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_cnt <= '0;
        end else if (out_valid) begin
            hold_cnt <= HOLD_W'(`FFT_SR_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign sr_valid = (hold_cnt != '0);

endmodule

`default_nettype wire

// ==== logic/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [7:0]  addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [15:0] count_t;

    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } axil_req_t;

    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } axil_rsp_t;

    typedef struct packed {
        logic enable;
        logic bypass;
        logic clear;   // Single-cycle pulse.
    } ctrl_t;

endpackage

`default_nettype wire

// ==== logic/fft_csr.sv ====
`default_nettype none
`include "fft_settings.svh"

module fft_csr (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::axil_req_t axil_req,
    output csr_pkg::axil_rsp_t axil_rsp,
    input  logic               blk_done,
    output csr_pkg::ctrl_t     ctrl
);

    logic            aw_ready;
    logic            w_ready;
    logic            b_valid;
    logic            ar_ready;
    logic            r_valid;
    logic            aw_got;
    logic            w_got;
    logic            wr_ctrl;
    csr_pkg::addr_t  wr_addr;
    csr_pkg::data_t  wr_data;
    csr_pkg::strb_t  wr_strb;
    csr_pkg::data_t  r_data;
    csr_pkg::data_t  rd_mux;
    csr_pkg::count_t blk_count;

    // The write lands once both address and data are held and no response is pending.
    assign wr_ctrl = aw_got && w_got && !b_valid && (wr_addr == `FFT_ADDR_CTRL) && wr_strb[0];

    always_comb begin
        case (axil_req.ar_addr)
            `FFT_ADDR_CTRL:  rd_mux = {30'd0, ctrl.bypass, ctrl.enable};
            `FFT_ADDR_COUNT: rd_mux = {16'd0, blk_count};
            `FFT_ADDR_ID:    rd_mux = `FFT_ID_VALUE;
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            ctrl     <= '0;
        end else begin
            // Ready pulses for one cycle, so each channel takes one beat.
            aw_ready <= !aw_ready && axil_req.aw_valid && !aw_got && !b_valid;
            w_ready  <= !w_ready && axil_req.w_valid && !w_got && !b_valid;
            ar_ready <= !ar_ready && axil_req.ar_valid && !r_valid;
            ctrl.clear <= wr_ctrl && wr_data[2];
            if (aw_ready && axil_req.aw_valid) aw_got <= 1'b1;
            if (w_ready && axil_req.w_valid) w_got <= 1'b1;
            if (aw_got && w_got && !b_valid) begin
                b_valid <= 1'b1;
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
            end else if (b_valid && axil_req.b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_ctrl) begin
                ctrl.enable <= wr_data[0];
                ctrl.bypass <= wr_data[1];
            end
            if (ar_ready && axil_req.ar_valid) begin
                r_valid <= 1'b1;
            end else if (r_valid && axil_req.r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_ready && axil_req.aw_valid) wr_addr <= axil_req.aw_addr;
        if (w_ready && axil_req.w_valid) begin
            wr_data <= axil_req.w_data;
            wr_strb <= axil_req.w_strb;
        end
        if (ar_ready && axil_req.ar_valid) r_data <= rd_mux;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            blk_count <= '0;
        end else if (ctrl.clear) begin
            blk_count <= '0;
        end else if (blk_done) begin
            blk_count <= blk_count + 16'd1;   // Wraps at 16 bits.
        end
    end

    always_comb begin
        axil_rsp.aw_ready = aw_ready;
        axil_rsp.w_ready  = w_ready;
        axil_rsp.b_valid  = b_valid;
        axil_rsp.b_resp   = '0;   // OKAY for every address.
        axil_rsp.ar_ready = ar_ready;
        axil_rsp.r_valid  = r_valid;
        axil_rsp.r_data   = r_data;
        axil_rsp.r_resp   = '0;
    end

endmodule

`default_nettype wire

// ==== logic/fft_pkg.sv ====
`default_nettype none
`include "fft_settings.svh"

package fft_pkg;

    typedef logic signed [9:0]  sample_t;
    typedef logic signed [10:0] sum_t;      // One bit of growth from a + b.
    typedef logic signed [9:0]  twiddle_t;  // Q2.8, so 256 is unity.
    typedef logic signed [12:0] result_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_in_t;

    typedef struct packed {
        result_t re;
        result_t im;
    } cplx_out_t;

    // Lane 0 sits in the least significant bits.
    typedef cplx_in_t  [`FFT_LANES-1:0] frame_in_t;
    typedef cplx_out_t [`FFT_LANES-1:0] frame_out_t;

    typedef struct packed {
        frame_in_t a;
        frame_in_t b;
    } pair_t;

    typedef struct packed {
        frame_out_t add;
        frame_out_t diff;
    } bfly_out_t;

endpackage

`default_nettype wire

// ==== logic/fft_top.sv ====
`default_nettype none

module fft_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  fft_pkg::frame_in_t in_frame,
    input  csr_pkg::axil_req_t axil_req,
    output csr_pkg::axil_rsp_t axil_rsp,
    output logic               out_valid,
    output fft_pkg::bfly_out_t out_data,
    output logic               sr_valid
);

    csr_pkg::ctrl_t ctrl;
    logic           pair_valid;
    fft_pkg::pair_t pair;

    // Each finished output block is counted by the register block.
    fft_csr i_csr (
        .clk      (clk),
        .rstn     (rstn),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .blk_done (out_valid),
        .ctrl     (ctrl)
    );

    frame_pairer i_pairer (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_frame   (in_frame),
        .ctrl       (ctrl),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    butterfly_stage i_bfly (
        .clk        (clk),
        .rstn       (rstn),
        .pair_valid (pair_valid),
        .pair       (pair),
        .ctrl       (ctrl),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .sr_valid   (sr_valid)
    );

endmodule

`default_nettype wire

// ==== logic/frame_pairer.sv ====
`default_nettype none

module frame_pairer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  fft_pkg::frame_in_t in_frame,
    input  csr_pkg::ctrl_t     ctrl,
    output logic               pair_valid,
    output fft_pkg::pair_t     pair
);

    logic               phase_b;   // High while the stored frame waits for its partner.
    logic               accept;
    fft_pkg::frame_in_t frame_a;

    // Frames arriving while disabled are dropped and leave the phase alone.
    assign accept = in_valid && ctrl.enable;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase_b    <= 1'b0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= accept && phase_b && !ctrl.clear;
            if (ctrl.clear) begin
                phase_b <= 1'b0;
            end else if (accept) begin
                phase_b <= !phase_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !phase_b) begin
            frame_a <= in_frame;
        end
        if (accept && phase_b) begin
            pair.a <= frame_a;
            pair.b <= in_frame;
        end
    end

endmodule

`default_nettype wire

// ==== test/fft_props.sv ====
`default_nettype none
`include "fft_settings.svh"

module fft_props (
    input logic               clk,
    input logic               rstn,
    input logic               out_valid,
    input logic               sr_valid,
    input csr_pkg::axil_req_t axil_req,
    input csr_pkg::axil_rsp_t axil_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fails = 0;

    a_reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> !sr_valid && !out_valid)
        else begin
            fails++;
            $error("sr_valid or out_valid is high when reset is released");
        end

    a_sr_rise: assert property (@(posedge clk) disable iff (!rstn) out_valid |=> sr_valid)
        else begin
            fails++;
            $error("sr_valid did not follow out_valid");
        end

    // The strobe is still high on the last cycle of the hold window.
    a_sr_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_valid ##1 (!out_valid)[*(`FFT_SR_HOLD - 1)] |=> sr_valid)
        else begin
            fails++;
            $error("sr_valid fell before the hold time ran out");
        end

    a_sr_fall: assert property (@(posedge clk) disable iff (!rstn)
        out_valid ##1 (!out_valid)[*`FFT_SR_HOLD] |=> !sr_valid)
        else begin
            fails++;
            $error("sr_valid stayed high past the hold time");
        end

    a_sr_source: assert property (@(posedge clk) disable iff (!rstn)
        $rose(sr_valid) |-> $past(out_valid))
        else begin
            fails++;
            $error("sr_valid rose without an output block");
        end

    a_b_stable: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.b_valid && !axil_req.b_ready |=>
            axil_rsp.b_valid && $stable(axil_rsp.b_resp))
        else begin
            fails++;
            $error("write response changed before it was accepted");
        end

    a_r_stable: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.r_valid && !axil_req.r_ready |=>
            axil_rsp.r_valid && $stable(axil_rsp.r_data) && $stable(axil_rsp.r_resp))
        else begin
            fails++;
            $error("read response changed before it was accepted");
        end

endmodule

bind fft_top fft_props i_props (
    .clk       (clk),
    .rstn      (rstn),
    .out_valid (out_valid),
    .sr_valid  (sr_valid),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp)
);

`default_nettype wire

// ==== test/tb_fft_top.sv ====
`default_nettype none
`include "fft_settings.svh"

module tb_fft_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles = 2000;

    logic               clk;
    logic               rstn;
    logic               in_valid;
    fft_pkg::frame_in_t in_frame;
    csr_pkg::axil_req_t axil_req;
    csr_pkg::axil_rsp_t axil_rsp;
    logic               out_valid;
    fft_pkg::bfly_out_t out_data;
    logic               sr_valid;

    int                 seed;
    int                 errors;
    int                 cycles;
    int                 blocks;        // Blocks since the last clear, as the model sees them.
    logic               model_enable;
    logic               model_bypass;
    logic               have_a;
    logic               second_mark;   // High with the frame that completes a pair.
    fft_pkg::frame_in_t frame_a;
    fft_pkg::bfly_out_t exp_q[$];
    fft_pkg::bfly_out_t exp_head;
    int                 exp_count;

    fft_top i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_frame (in_frame),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .out_valid(out_valid),
        .out_data (out_data),
        .sr_valid (sr_valid)
    );

    always #4 clk = ~clk;

    function automatic fft_pkg::frame_in_t random_frame();
        fft_pkg::frame_in_t f;
        logic [31:0]        r;
        for (int i = 0; i < `FFT_LANES; i++) begin
            r = $random(seed);
            f[i].re = r[9:0];
            f[i].im = r[25:16];
        end
        return f;
    endfunction

    // Add branch {1, 1, 1, 0.707-0.707j}, diff branch {1, -j, 1, -0.707-0.707j}.
    function automatic void table_entry(input int idx, input logic diff,
                                        output int wr, output int wi);
        wr = 256;
        wi = 0;
        if (!diff && idx == 3) begin
            wr = 181;
            wi = -181;
        end
        if (diff && idx == 1) begin
            wr = 0;
            wi = -256;
        end
        if (diff && idx == 3) begin
            wr = -181;
            wi = -181;
        end
    endfunction

    function automatic fft_pkg::cplx_out_t twiddle_mult(int xr, int xi, int wr, int wi);
        fft_pkg::cplx_out_t y;
        y.re = fft_pkg::result_t'((xr * wr - xi * wi) >>> `FFT_TW_FRAC);
        y.im = fft_pkg::result_t'((xr * wi + xi * wr) >>> `FFT_TW_FRAC);
        return y;
    endfunction

    function automatic fft_pkg::bfly_out_t model_block(fft_pkg::frame_in_t a,
                                                       fft_pkg::frame_in_t b,
                                                       int idx, logic bypass);
        fft_pkg::bfly_out_t y;
        int sr;
        int si;
        int dr;
        int di;
        int awr;
        int awi;
        int dwr;
        int dwi;
        table_entry(bypass ? 0 : idx, 1'b0, awr, awi);   // Entry 0 is unity.
        table_entry(bypass ? 0 : idx, 1'b1, dwr, dwi);
        for (int i = 0; i < `FFT_LANES; i++) begin
            sr = int'(a[i].re) + int'(b[i].re);
            si = int'(a[i].im) + int'(b[i].im);
            dr = int'(a[i].re) - int'(b[i].re);
            di = int'(a[i].im) - int'(b[i].im);
            y.add[i] = twiddle_mult(sr, si, awr, awi);
            y.diff[i] = twiddle_mult(dr, di, dwr, dwi);
        end
        return y;
    endfunction

    function automatic void refresh_head();
        exp_count = exp_q.size();
        exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
    endfunction

    task automatic axil_write(input csr_pkg::addr_t addr, input csr_pkg::data_t data);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        @(posedge clk);
        axil_req.aw_valid <= 1'b1;
        axil_req.aw_addr <= addr;
        axil_req.w_valid <= 1'b1;
        axil_req.w_data <= data;
        axil_req.w_strb <= 4'hF;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (axil_rsp.aw_ready) begin
                aw_done = 1'b1;
                axil_req.aw_valid <= 1'b0;
            end
            if (axil_rsp.w_ready) begin
                w_done = 1'b1;
                axil_req.w_valid <= 1'b0;
            end
        end
        do @(posedge clk); while (!axil_rsp.b_valid);
        axil_req.b_ready <= 1'b1;   // One stall cycle before the response is taken.
        @(posedge clk);
        axil_req.b_ready <= 1'b0;
    endtask

    task automatic axil_read(input csr_pkg::addr_t addr, output csr_pkg::data_t data);
        @(posedge clk);
        axil_req.ar_valid <= 1'b1;
        axil_req.ar_addr <= addr;
        do @(posedge clk); while (!axil_rsp.ar_ready);
        axil_req.ar_valid <= 1'b0;
        do @(posedge clk); while (!axil_rsp.r_valid);
        axil_req.r_ready <= 1'b1;
        @(posedge clk);
        data = axil_rsp.r_data;
        axil_req.r_ready <= 1'b0;
    endtask

    task automatic check_reg(input csr_pkg::addr_t addr, input csr_pkg::data_t expected,
                             input string name);
        csr_pkg::data_t got;
        axil_read(addr, got);
        assert (got == expected)
            else begin
                errors++;
                $display("CHECK FAILED at %0t: %s expected %h got %h",
                         $time, name, expected, got);
            end
    endtask

    task automatic write_ctrl(input logic en, input logic byp, input logic clr);
        axil_write(`FFT_ADDR_CTRL, {29'd0, clr, byp, en});
        model_enable = en;
        model_bypass = byp;
        if (clr) begin
            blocks = 0;
            have_a = 1'b0;
        end
    endtask

    task automatic send_frame();
        fft_pkg::frame_in_t f;
        logic               is_second;
        f = random_frame();
        is_second = 1'b0;
        @(posedge clk);
        if (model_enable) begin
            if (have_a) begin
                exp_q.push_back(model_block(frame_a, f, (blocks >> 2) & 3, model_bypass));
                blocks++;
                is_second = 1'b1;
            end else begin
                frame_a = f;
            end
            have_a = !have_a;
            refresh_head();
        end
        in_valid <= 1'b1;
        in_frame <= f;
        second_mark <= is_second;
    endtask

    task automatic stop_input();
        @(posedge clk);
        in_valid <= 1'b0;
        second_mark <= 1'b0;
    endtask

    // Waits for the model queue to empty and the strobe to run out.
    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
        while (sr_valid) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (rstn && out_valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_block_expected: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> exp_count != 0)
        else begin
            errors++;
            $display("Output block at %0t was not expected by the model", $time);
        end

    a_block_value: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && exp_count != 0 |-> out_data == exp_head)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: out_data expected %h got %h",
                     $time, $sampled(exp_head), $sampled(out_data));
        end

    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        second_mark |-> ##3 out_valid)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: out_valid expected 1 got 0", $time);
        end

    // Every address, mapped or not, answers OKAY.
    a_write_okay: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.b_valid |-> axil_rsp.b_resp == 2'b00)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: b_resp expected 0 got %0d",
                     $time, $sampled(axil_rsp.b_resp));
        end

    a_read_okay: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.r_valid |-> axil_rsp.r_resp == 2'b00)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: r_resp expected 0 got %0d",
                     $time, $sampled(axil_rsp.r_resp));
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        in_valid = 1'b0;
        in_frame = '0;
        axil_req = '0;
        seed = 32'h27096f67;
        errors = 0;
        cycles = 0;
        blocks = 0;
        model_enable = 1'b0;
        model_bypass = 1'b0;
        have_a = 1'b0;
        second_mark = 1'b0;
        frame_a = '0;
        refresh_head();
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        check_reg(`FFT_ADDR_ID, `FFT_ID_VALUE, "ID");
        check_reg(8'h0C, 32'd0, "unmapped");

        write_ctrl(1'b1, 1'b1, 1'b0);
        check_reg(`FFT_ADDR_CTRL, 32'd3, "CTRL");
        repeat (8) send_frame();
        stop_input();
        drain();
        check_reg(`FFT_ADDR_COUNT, blocks, "COUNT");

        // Sixteen blocks walk all four table entries.
        write_ctrl(1'b1, 1'b0, 1'b1);
        check_reg(`FFT_ADDR_COUNT, 32'd0, "COUNT");
        repeat (32) send_frame();
        stop_input();
        drain();
        check_reg(`FFT_ADDR_COUNT, blocks, "COUNT");

        // An A frame waits while three frames are dropped.
        send_frame();
        stop_input();
        write_ctrl(1'b0, 1'b0, 1'b0);
        repeat (3) send_frame();
        stop_input();
        write_ctrl(1'b1, 1'b0, 1'b0);
        repeat (9) send_frame();
        stop_input();
        drain();
        check_reg(`FFT_ADDR_COUNT, blocks, "COUNT");

        write_ctrl(1'b1, 1'b0, 1'b1);
        check_reg(`FFT_ADDR_COUNT, 32'd0, "COUNT");
        repeat (2) send_frame();
        stop_input();
        drain();
        check_reg(`FFT_ADDR_COUNT, 32'd1, "COUNT");

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected output blocks never arrived", exp_q.size());
        end
        $display("Errors: %0d testbench, %0d property; blocks checked after last clear: %0d",
                 errors, i_dut.i_props.fails, blocks);
        if (errors == 0 && i_dut.i_props.fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
